// ==== verilog.f ====
hdl/evrPkg.sv
hdl/commaAlign.sv
hdl/actionTable.sv
hdl/markerStretch.sv
hdl/evrReceiver.sv
tests/evrReceiver_assertions.sv
tests/evrReceiver_tb.sv

// ==== Bender.yml ====
package:
  name: evr_receiver

sources:
  - hdl/evrPkg.sv
  - hdl/commaAlign.sv
  - hdl/actionTable.sv
  - hdl/markerStretch.sv
  - hdl/evrReceiver.sv
  - target: test
    files:
      - tests/evrReceiver_assertions.sv
      - tests/evrReceiver_tb.sv

// ==== tests/evrReceiver_tb.sv ====
// testbench for the event receiver, drives the decoded link and reports the checker result

`timescale 1ns/1ps

module evrReceiver_tb;

    localparam int COMMAS_NEEDED  = 8;
    localparam int OUTPUT_COUNT   = 4;
    localparam int STRETCH_CYCLES = 5;
    localparam int MAPPED_CODES   = 47;   // codes above this stay unmapped
    localparam int RANDOM_WORDS   = 300;
    localparam int TIMEOUT_CYCLES = 2000; // about four times the stimulus length

    logic                          evrClk;
    logic                          rst_i;
    logic [evrPkg::WORD_WIDTH-1:0] rxData_i;
    logic [1:0]                    rxIsK_i;
    logic [1:0]                    rxNotInTable_i;
    logic                          slideRequest_i;
    logic                          actionWrite_i;
    evrPkg::evrCode_t              actionAddr_i;
    logic [OUTPUT_COUNT-1:0]       actionData_i;
    logic                          rxIsAligned_o;
    logic                          bitSlide_o;
    evrPkg::evrCode_t              evrCode_o;
    logic                          evrCodeValid_o;
    logic [OUTPUT_COUNT-1:0]       evrTriggerBus_o;
    int                            cycleCount = 0;
    int                            failTotal;

    evrReceiver #(
        .COMMAS_NEEDED  (COMMAS_NEEDED),
        .OUTPUT_COUNT   (OUTPUT_COUNT),
        .STRETCH_CYCLES (STRETCH_CYCLES)
    ) dut_i (.*);

    initial begin
        evrClk = 1'b0;
        forever #50 evrClk = ~evrClk;  // 100 ns period
    end

    always @(posedge evrClk) cycleCount <= cycleCount + 1;

    //////////////////////////////
    // stimulus tasks
    //////////////////////////////

    task automatic sendWord(input logic [15:0] data, input logic [1:0] isK,
                            input logic [1:0] notInTable);
        @(posedge evrClk);
        rxData_i       <= data;
        rxIsK_i        <= isK;
        rxNotInTable_i <= notInTable;
    endtask

    task automatic sendComma();
        sendWord({8'h00, evrPkg::COMMA_CODE}, 2'b01, 2'b00);  // K28.5 on the lower byte
    endtask

    task automatic sendIdle();
        logic [7:0] upper;
        upper = 8'($urandom);  // upper byte carries unrelated data
        sendWord({upper, 8'h00}, 2'b00, 2'b00);
    endtask

    task automatic sendCode(input evrPkg::evrCode_t code);
        logic [7:0] upper;
        upper = 8'($urandom);
        sendWord({upper, code}, 2'b00, 2'b00);
    endtask

    task automatic writeEntry(input evrPkg::evrCode_t code);
        logic [OUTPUT_COUNT-1:0] bits;
        bits = '0;
        bits[code % OUTPUT_COUNT] = 1'b1;  // one trigger bit per code
        @(posedge evrClk);
        actionWrite_i <= 1'b1;
        actionAddr_i  <= code;
        actionData_i  <= bits;
    endtask

    // idle, comma and code words in random order
    task automatic sendTraffic(input int count);
        for (int n = 0; n < count; n++) begin
            case ($urandom_range(0, 7))
                0, 1:    sendIdle();
                2:       sendComma();
                default: sendCode(8'($urandom_range(1, 63)));
            endcase
        end
    endtask

    task automatic holdSlide(input int cycles);
        @(posedge evrClk);
        slideRequest_i <= 1'b1;
        repeat (cycles) @(posedge evrClk);
        slideRequest_i <= 1'b0;
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        void'($urandom(32'h9d6a));
        rst_i          = 1'b1;
        rxData_i       = '0;
        rxIsK_i        = '0;
        rxNotInTable_i = '0;
        slideRequest_i = 1'b0;
        actionWrite_i  = 1'b0;
        actionAddr_i   = '0;
        actionData_i   = '0;
        repeat (16) @(posedge evrClk);
        rst_i <= 1'b0;

        for (int c = 1; c <= MAPPED_CODES; c++) begin
            writeEntry(8'(c));
        end
        @(posedge evrClk);
        actionWrite_i <= 1'b0;

        // partial lock, then a coding error restarts the count
        repeat (COMMAS_NEEDED - 3) sendComma();
        sendCode(8'h11);                                         // not aligned yet
        sendWord({8'h00, evrPkg::COMMA_CODE}, 2'b01, 2'b01);     // comma with a table miss
        repeat (COMMAS_NEEDED) sendComma();

        sendTraffic(RANDOM_WORDS);

        // K on the upper byte drops lock, then relock
        sendWord({evrPkg::COMMA_CODE, 8'h22}, 2'b10, 2'b00);
        repeat (4) sendCode(8'($urandom_range(1, 63)));
        repeat (COMMAS_NEEDED) sendComma();
        sendTraffic(20);
        sendWord({8'h00, 8'h05}, 2'b00, 2'b10);  // upper byte table miss
        repeat (3) sendIdle();

        holdSlide(6);  // held request
        repeat (3) @(posedge evrClk);
        holdSlide(1);
        repeat (STRETCH_CYCLES + 10) @(posedge evrClk);

        failTotal = dut_i.checker_i.failCount;
        $display("closing report: %0d assertion failures in %0d cycles", failTotal, cycleCount);
        if (failTotal == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin : watchdog
        wait (cycleCount >= TIMEOUT_CYCLES);
        $display("run timed out after %0d cycles before the stimulus ended", cycleCount);
        $display("Finished with errors");
        $finish;
    end

endmodule

// ==== tests/evrReceiver_assertions.sv ====
// bound checker for the event receiver, shadow action table and concurrent assertions

`timescale 1ns/1ps

module evrReceiverAssertions #(
    parameter int COMMAS_NEEDED  = 60,
    parameter int OUTPUT_COUNT   = 8,
    parameter int STRETCH_CYCLES = 4
) (
    input logic                          evrClk,
    input logic                          rst_i,
    input logic [evrPkg::WORD_WIDTH-1:0] rxData_i,
    input logic [1:0]                    rxIsK_i,
    input logic [1:0]                    rxNotInTable_i,
    input logic                          slideRequest_i,
    input logic                          actionWrite_i,
    input evrPkg::evrCode_t              actionAddr_i,
    input logic [OUTPUT_COUNT-1:0]       actionData_i,
    input logic                          rxIsAligned_o,
    input logic                          bitSlide_o,
    input evrPkg::evrCode_t              evrCode_o,
    input logic                          evrCodeValid_o,
    input logic [OUTPUT_COUNT-1:0]       evrTriggerBus_o
);

    int                      failCount = 0;  // read by the testbench at the end
    evrPkg::alignState_t     expState;       // reference aligner
    int                      huntCommas;     // clean commas seen in HUNT
    logic [OUTPUT_COUNT-1:0] shadowMem [256];
    logic                    expValid;       // reference code strobe
    evrPkg::evrCode_t        expCode;        // reference code byte
    logic [OUTPUT_COUNT-1:0] hitVec;         // expected lookup result
    logic [OUTPUT_COUNT-1:0] hitD1;          // lookup one edge later, as action bits
    evrPkg::evrCode_t        lowByte;
    logic                    linkErr;
    logic                    cleanComma;
    logic                    qualified;

    assign lowByte    = rxData_i[evrPkg::BYTE_WIDTH-1:0];
    assign linkErr    = (rxNotInTable_i != 2'b00) || rxIsK_i[1];
    assign cleanComma = !linkErr && rxIsK_i[0] && (lowByte == evrPkg::COMMA_CODE);
    assign qualified  = (expState == evrPkg::LOCKED) && (lowByte != '0) && !rxIsK_i[0];
    assign hitVec     = expValid ? shadowMem[expCode] : '0;

    //////////////////////////////
    // reference models
    //////////////////////////////

    always_ff @(posedge evrClk) begin
        if (rst_i || linkErr) begin
            expState   <= evrPkg::HUNT;
            huntCommas <= 0;
        end else if ((expState == evrPkg::HUNT) && cleanComma) begin
            if (huntCommas == COMMAS_NEEDED - 1) begin
                expState <= evrPkg::LOCKED;
            end else begin
                huntCommas <= huntCommas + 1;
            end
        end
    end

    always_ff @(posedge evrClk) begin
        if (rst_i) begin
            for (int i = 0; i < 256; i++) begin
                shadowMem[i] <= '0;
            end
            expValid <= 1'b0;
            expCode  <= '0;
            hitD1    <= '0;
        end else begin
            if (actionWrite_i) begin
                shadowMem[actionAddr_i] <= actionData_i;
            end
            expValid <= qualified;  // one cycle code latency
            expCode  <= lowByte;
            hitD1    <= hitVec;     // old entry on a write edge
        end
    end

    //////////////////////////////
    // link and code checks
    //////////////////////////////

    resetOutputs: assert property (@(posedge evrClk) $past(rst_i) |-> !rxIsAligned_o &&
        !bitSlide_o && !evrCodeValid_o && (evrCode_o == '0) && (evrTriggerBus_o == '0))
        else begin
            failCount++;
            $error("** Error @ %0t: outputs not low after reset", $time);
        end

    alignMatch: assert property (@(posedge evrClk) disable iff (rst_i)
        rxIsAligned_o == (expState == evrPkg::LOCKED))
        else begin
            failCount++;
            $error("** Error @ %0t: rxIsAligned_o disagrees with comma count", $time);
        end

    alignDrop: assert property (@(posedge evrClk) disable iff (rst_i) linkErr |=> !rxIsAligned_o)
        else begin
            failCount++;
            $error("** Error @ %0t: alignment kept after a coding error", $time);
        end

    codeOut: assert property (@(posedge evrClk) disable iff (rst_i)
        qualified |=> evrCodeValid_o && (evrCode_o == $past(lowByte)))
        else begin
            failCount++;
            $error("** Error @ %0t: qualified code missing or wrong", $time);
        end

    codeQuiet: assert property (@(posedge evrClk) disable iff (rst_i)
        !qualified |=> !evrCodeValid_o && (evrCode_o == '0))
        else begin
            failCount++;
            $error("** Error @ %0t: code output on an unqualified word", $time);
        end

    slidePulse: assert property (@(posedge evrClk) disable iff (rst_i)
        $rose(slideRequest_i) |-> ##2 bitSlide_o ##1 !bitSlide_o)
        else begin
            failCount++;
            $error("** Error @ %0t: bit slide pulse missing or too long", $time);
        end

    slideOnly: assert property (@(posedge evrClk) disable iff (rst_i)
        bitSlide_o |-> $past(slideRequest_i, 2) && !$past(slideRequest_i, 3))
        else begin
            failCount++;
            $error("** Error @ %0t: bit slide without a new request", $time);
        end

    //////////////////////////////
    // trigger checks
    //////////////////////////////

    for (genvar i = 0; i < OUTPUT_COUNT; i++) begin : gen_bit
        int age;  // cycles since the last action bit, saturates at the pulse width

        always_ff @(posedge evrClk) begin
            if (rst_i) begin
                age <= STRETCH_CYCLES;
            end else if (hitD1[i]) begin
                age <= 0;
            end else if (age < STRETCH_CYCLES) begin
                age <= age + 1;
            end
        end

        trigRise: assert property (@(posedge evrClk) disable iff (rst_i)
            hitVec[i] |-> ##2 evrTriggerBus_o[i])
            else begin
                failCount++;
                $error("** Error @ %0t: trigger %0d did not rise", $time, i);
            end

        trigWindow: assert property (@(posedge evrClk) disable iff (rst_i)
            evrTriggerBus_o[i] == (age < STRETCH_CYCLES))
            else begin
                failCount++;
                $error("** Error @ %0t: trigger %0d has wrong width", $time, i);
            end
    end

endmodule

bind evrReceiver evrReceiverAssertions #(
    .COMMAS_NEEDED  (COMMAS_NEEDED),
    .OUTPUT_COUNT   (OUTPUT_COUNT),
    .STRETCH_CYCLES (STRETCH_CYCLES)
) checker_i (.*);

// ==== hdl/evrReceiver.sv ====
// event receiver fabric top with aligner, action table and trigger stretchers

`timescale 1ns/1ps

module evrReceiver #(
    parameter int COMMAS_NEEDED  = 60,
    parameter int OUTPUT_COUNT   = 8,
    parameter int STRETCH_CYCLES = 4
) (
    input  logic                          evrClk,
    input  logic                          rst_i,

    // decoded stream from the transceiver
    input  logic [evrPkg::WORD_WIDTH-1:0] rxData_i,
    input  logic [1:0]                    rxIsK_i,
    input  logic [1:0]                    rxNotInTable_i,
    input  logic                          slideRequest_i,

    // action table write port
    input  logic                          actionWrite_i,
    input  evrPkg::evrCode_t              actionAddr_i,
    input  logic [OUTPUT_COUNT-1:0]       actionData_i,

    // link status and events
    output logic                          rxIsAligned_o,
    output logic                          bitSlide_o,  // to transceiver slide input
    output evrPkg::evrCode_t              evrCode_o,
    output logic                          evrCodeValid_o,
    output logic [OUTPUT_COUNT-1:0]       evrTriggerBus_o
);

    logic [OUTPUT_COUNT-1:0] action; // one cycle per valid code

    //////////////////////////////
    // alignment and code capture
    //////////////////////////////

    commaAlign #(
        .COMMAS_NEEDED (COMMAS_NEEDED)
    ) align_i (
        .evrClk         (evrClk),
        .rst_i          (rst_i),
        .rxData_i       (rxData_i),
        .rxIsK_i        (rxIsK_i),
        .rxNotInTable_i (rxNotInTable_i),
        .slideRequest_i (slideRequest_i),
        .rxIsAligned_o  (rxIsAligned_o),
        .bitSlide_o     (bitSlide_o),
        .evrCode_o      (evrCode_o),
        .evrCodeValid_o (evrCodeValid_o)
    );

    //////////////////////////////
    // code to action mapping
    //////////////////////////////

    actionTable #(
        .OUTPUT_COUNT (OUTPUT_COUNT)
    ) table_i (
        .evrClk         (evrClk),
        .rst_i          (rst_i),
        .evrCode_i      (evrCode_o),
        .evrCodeValid_i (evrCodeValid_o),
        .actionWrite_i  (actionWrite_i),
        .actionAddr_i   (actionAddr_i),
        .actionData_i   (actionData_i),
        .action_o       (action)
    );

    //////////////////////////////
    // trigger stretchers
    //////////////////////////////

    // one channel per action bit, straight to the trigger bus
    for (genvar i = 0; i < OUTPUT_COUNT; i++) begin : gen_stretch
        markerStretch #(
            .STRETCH_CYCLES (STRETCH_CYCLES)
        ) stretch_i (
            .evrClk   (evrClk),
            .rst_i    (rst_i),
            .action_i (action[i]),
            .marker_o (evrTriggerBus_o[i])
        );
    end

endmodule

// ==== hdl/markerStretch.sv ====
// single trigger channel, stretches an action pulse to a fixed width

`timescale 1ns/1ps

module markerStretch #(
    parameter int STRETCH_CYCLES = 4
) (
    input  logic evrClk,
    input  logic rst_i,
    input  logic action_i,  // one-cycle action bit
    output logic marker_o   // stretched trigger
);

    // wide enough to hold the full pulse length
    localparam int CNT_WIDTH = $clog2(STRETCH_CYCLES + 1);
    localparam logic [CNT_WIDTH-1:0] COUNT_LOAD = CNT_WIDTH'(STRETCH_CYCLES);

    logic [CNT_WIDTH-1:0] stretchCount; // cycles of pulse left

    //////////////////////////////
    // down-counter
    //////////////////////////////

    always_ff @(posedge evrClk) begin
        if (rst_i) begin
            stretchCount <= '0;
        end else if (action_i) begin
            stretchCount <= COUNT_LOAD;   // new pulse restarts the window
        end else if (stretchCount != '0) begin
            stretchCount <= stretchCount - 1'b1;
        end
    end

    // high for exactly STRETCH_CYCLES cycles after the last action
    assign marker_o = (stretchCount != '0);

endmodule

// ==== hdl/actionTable.sv ====
// event code to action table with write port and registered lookup

`timescale 1ns/1ps

module actionTable #(
    parameter int OUTPUT_COUNT = 8
) (
    input  logic                    evrClk,
    input  logic                    rst_i,
    input  evrPkg::evrCode_t        evrCode_i,
    input  logic                    evrCodeValid_i,
    input  logic                    actionWrite_i, // one-cycle write strobe
    input  evrPkg::evrCode_t        actionAddr_i,
    input  logic [OUTPUT_COUNT-1:0] actionData_i,
    output logic [OUTPUT_COUNT-1:0] action_o
);

    // one entry per possible code
    localparam int TABLE_DEPTH = 2 ** evrPkg::BYTE_WIDTH;

    logic [OUTPUT_COUNT-1:0] actionMem [TABLE_DEPTH];

    //////////////////////////////
    // table write
    //////////////////////////////

    // reset leaves every code unmapped
    always_ff @(posedge evrClk) begin
        if (rst_i) begin
            for (int i = 0; i < TABLE_DEPTH; i++) begin
                actionMem[i] <= '0;
            end
        end else if (actionWrite_i) begin
            actionMem[actionAddr_i] <= actionData_i;
        end
    end

    //////////////////////////////
    // lookup
    //////////////////////////////

    // a lookup on the write edge still sees the old entry
    always_ff @(posedge evrClk) begin
        if (rst_i) begin
            action_o <= '0;
        end else if (evrCodeValid_i) begin
            action_o <= actionMem[evrCode_i];
        end else begin
            action_o <= '0; // no code, no action
        end
    end

endmodule

// ==== hdl/commaAlign.sv ====
// comma alignment detector with bit-slide pulse and event code qualification

`timescale 1ns/1ps

module commaAlign #(
    parameter int COMMAS_NEEDED = 60
) (
    input  logic                          evrClk,
    input  logic                          rst_i,
    input  logic [evrPkg::WORD_WIDTH-1:0] rxData_i,
    input  logic [1:0]                    rxIsK_i,        // per-byte K flags
    input  logic [1:0]                    rxNotInTable_i, // per-byte code errors
    input  logic                          slideRequest_i,
    output logic                          rxIsAligned_o,
    output logic                          bitSlide_o,
    output evrPkg::evrCode_t              evrCode_o,
    output logic                          evrCodeValid_o
);

    // counter sized for the reload value, at least one bit
    localparam int CNT_WIDTH = (COMMAS_NEEDED > 1) ? $clog2(COMMAS_NEEDED) : 1;
    localparam logic [CNT_WIDTH-1:0] COUNT_RELOAD = CNT_WIDTH'(COMMAS_NEEDED - 1);

    evrPkg::alignState_t    alignState;
    logic [CNT_WIDTH-1:0]   commaCount;  // commas still to see in HUNT
    evrPkg::evrCode_t       lowByte;
    logic                   linkError;
    logic                   cleanComma;
    logic                   goodCode;
    logic                   slideD0;     // first request stage
    logic                   slideD1;     // second request stage, edge reference

    //////////////////////////////
    // word decode
    //////////////////////////////

    assign lowByte = rxData_i[evrPkg::BYTE_WIDTH-1:0];

    // any table miss or a K on the upper byte means we are misaligned
    assign linkError = (rxNotInTable_i != 2'b00) || rxIsK_i[1];

    assign cleanComma = !linkError && rxIsK_i[0] && (lowByte == evrPkg::COMMA_CODE);

    // only a locked link passes data bytes, zero is the idle code
    assign goodCode = (alignState == evrPkg::LOCKED) && (lowByte != '0) && !rxIsK_i[0];

    //////////////////////////////
    // alignment FSM
    //////////////////////////////

    always_ff @(posedge evrClk) begin
        if (rst_i) begin
            alignState <= evrPkg::HUNT;
            commaCount <= COUNT_RELOAD;
        end else if (linkError) begin
            // drop lock and start the count over
            alignState <= evrPkg::HUNT;
            commaCount <= COUNT_RELOAD;
        end else if ((alignState == evrPkg::HUNT) && cleanComma) begin
            if (commaCount == '0) begin
                alignState <= evrPkg::LOCKED; // last comma needed
            end else begin
                commaCount <= commaCount - 1'b1;
            end
        end
    end

    assign rxIsAligned_o = (alignState == evrPkg::LOCKED);

    //////////////////////////////
    // event code register
    //////////////////////////////

    always_ff @(posedge evrClk) begin
        if (rst_i) begin
            evrCode_o      <= '0;
            evrCodeValid_o <= 1'b0;
        end else begin
            evrCode_o      <= goodCode ? lowByte : '0; // zero when not qualified
            evrCodeValid_o <= goodCode;
        end
    end

    //////////////////////////////
    // bit slide
    //////////////////////////////

    // rising edge of the request gives one pulse, a held request gives nothing more
    always_ff @(posedge evrClk) begin
        if (rst_i) begin
            slideD0    <= 1'b0;
            slideD1    <= 1'b0;
            bitSlide_o <= 1'b0;
        end else begin
            slideD0    <= slideRequest_i;
            slideD1    <= slideD0;
            bitSlide_o <= slideD0 && !slideD1;
        end
    end

endmodule

// ==== hdl/evrPkg.sv ====
// event receiver shared definitions for word layout, comma code and aligner state

package evrPkg;

    //////////////////////////////
    // decoded word layout
    //////////////////////////////

    // one 8b/10b decoded byte
    localparam int BYTE_WIDTH = 8;

    // two bytes per received word, event code in the lower byte
    localparam int WORD_WIDTH = 16;

    // event code as carried on the lower byte
    typedef logic [BYTE_WIDTH-1:0] evrCode_t;

    //////////////////////////////
    // control characters
    //////////////////////////////

    // K28.5, the comma used for alignment
    localparam evrCode_t COMMA_CODE = 8'hBC;

    //////////////////////////////
    // aligner state
    //////////////////////////////

    typedef enum logic {
        HUNT   = 1'b0, // counting clean commas
        LOCKED = 1'b1  // link aligned, codes pass
    } alignState_t;

endpackage
